// ==== test/feature_core_stim.txt ====
// per frame: ctrl, initial thresh (100 keeps it), busy-time checks (1 = on), 8 image rows
// (column 0 in the low byte), expected count, expected thresh, keypoints as row*8+col
5
// filter off, flat image, border pixels differ from the blur
0 100 0
4040404040404040 4040404040404040 4040404040404040 4040404040404040
4040404040404040 4040404040404040 4040404040404040 4040404040404040
1c 10
00 01 02 03 04 05 06 07
08 0f 10 17 18 1f 20 27
28 2f 30 37 38 39 3a 3b
3c 3d 3e 3f
// filter on at 20, only the corners stay
1 14 1
4040404040404040 4040404040404040 4040404040404040 4040404040404040
4040404040404040 4040404040404040 4040404040404040 4040404040404040
04 14
00 07 38 3f
// adaptive mode 0 from 10, 28 keypoints raise it to 14
3 0a 0
4040404040404040 4040404040404040 4040404040404040 4040404040404040
4040404040404040 4040404040404040 4040404040404040 4040404040404040
1c 0e
00 01 02 03 04 05 06 07 08 0f 10 17 18 1f 20 27
28 2f 30 37 38 39 3a 3b 3c 3d 3e 3f
// same image, carried threshold 14 goes to 18
3 100 0
4040404040404040 4040404040404040 4040404040404040 4040404040404040
4040404040404040 4040404040404040 4040404040404040 4040404040404040
1c 12
00 01 02 03 04 05 06 07 08 0f 10 17 18 1f 20 27
28 2f 30 37 38 39 3a 3b 3c 3d 3e 3f
// adaptive mode 1 from 2, single bright pixel at row 3 col 3
7 02 0
0 0 0 00000000a0000000
0 0 0 0
09 00
12 13 14 1a 1b 1c 22 23 24

// ==== feature_core.f ====
hw/feature_pkg.sv
hw/mem_rw_if.sv
hw/row_mem.sv
hw/detect_config_regs.sv
hw/frame_sequencer.sv
hw/gaussian_blur.sv
hw/keypoint_detect.sv
hw/feature_core_top.sv
test/feature_core_checker.sv
test/tb_feature_core.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_feature_core
RTL_TOP   ?= feature_core_top
FILELIST  ?= feature_core.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal
LINTFLAGS ?= --lint-only -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TEST OK" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) hw/feature_pkg.sv hw/mem_rw_if.sv \
		hw/row_mem.sv hw/detect_config_regs.sv hw/frame_sequencer.sv \
		hw/gaussian_blur.sv hw/keypoint_detect.sv hw/feature_core_top.sv

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== test/tb_feature_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;    // 100 ns period
    end

    initial begin
        rst_n = 1'b0;
        repeat (2) @(posedge clk);
        #10 rst_n = 1'b1;
    end

endmodule

module tb_feature_core import feature_pkg::*; ();

    localparam int TIMEOUT = 2000;

    logic              clk;
    logic              rst_n;
    logic              start;
    logic              done;
    logic              busy;
    logic              img_we;
    logic [ROW_AW-1:0] img_waddr;
    img_row_t          img_wdata;
    logic [KPT_AW-1:0] kpt_rd_addr;
    kpt_t              kpt_rd_data;
    logic [3:0]        paddr;
    logic [3:0]        tb_paddr;
    logic [3:0]        chk_paddr;
    logic              psel;
    logic              tb_psel;
    logic              chk_psel;
    logic              penable;
    logic              tb_penable;
    logic              chk_penable;
    logic              pwrite;
    logic              tb_pwrite;
    logic [31:0]       pwdata;
    logic [31:0]       tb_pwdata;
    logic [31:0]       prdata;
    logic              pready;
    logic              pslverr;
    logic              bus_own;
    logic              chk_abort;
    int                req_seq;
    int                ack_seq;
    int                pass_count;
    int                fail_count;
    logic [63:0]       stim [0:255];

    // checker borrows the apb bus for its readback
    assign paddr   = bus_own ? chk_paddr : tb_paddr;
    assign psel    = bus_own ? chk_psel : tb_psel;
    assign penable = bus_own ? chk_penable : tb_penable;
    assign pwrite  = bus_own ? 1'b0 : tb_pwrite;
    assign pwdata  = tb_pwdata;

    tb_clock_gen u_clk (
        .clk   (clk),
        .rst_n (rst_n)
    );

    feature_core_top DUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (start),
        .done        (done),
        .busy        (busy),
        .img_we      (img_we),
        .img_waddr   (img_waddr),
        .img_wdata   (img_wdata),
        .kpt_rd_addr (kpt_rd_addr),
        .kpt_rd_data (kpt_rd_data),
        .paddr       (paddr),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .pwdata      (pwdata),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr)
    );

    feature_core_checker u_checker (
        .clk         (clk),
        .rst_n       (rst_n),
        .done        (done),
        .busy        (busy),
        .pslverr     (pslverr),
        .pready      (pready),
        .prdata      (prdata),
        .kpt_rd_data (kpt_rd_data),
        .req_seq     (req_seq),
        .kpt_rd_addr (kpt_rd_addr),
        .chk_paddr   (chk_paddr),
        .chk_psel    (chk_psel),
        .chk_penable (chk_penable),
        .bus_own     (bus_own),
        .ack_seq     (ack_seq),
        .pass_count  (pass_count),
        .fail_count  (fail_count),
        .abort       (chk_abort)
    );

    task automatic end_run(input bit ok);
        $display("tests passed: %0d, tests failed: %0d", pass_count, fail_count);
        if (ok) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    endtask

    task automatic apb_access(input logic [3:0] addr, input logic write, input logic [31:0] data);
        @(posedge clk);
        #10;
        tb_paddr   = addr;
        tb_pwdata  = data;
        tb_pwrite  = write;
        tb_psel    = 1'b1;
        tb_penable = 1'b0;
        @(posedge clk);
        #10;
        tb_penable = 1'b1;       // access phase, no wait states
        @(posedge clk);
        #10;
        tb_psel    = 1'b0;
        tb_penable = 1'b0;
        tb_pwrite  = 1'b0;
    endtask

    task automatic load_image(input int base);
        for (int r = 0; r < IMG_H; r++) begin
            @(posedge clk);
            #10;
            img_we    = 1'b1;
            img_waddr = ROW_AW'(r);
            img_wdata = stim[base+r];
        end
        @(posedge clk);
        #10;
        img_we = 1'b0;
    endtask

    task automatic pulse_start();
        @(posedge clk);
        #10;
        start = 1'b1;
        @(posedge clk);
        #10;
        start = 1'b0;
    endtask

    task automatic wait_busy();
        int cycles;
        cycles = 0;
        while (!busy && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (!busy) begin
            $display("timeout: busy never rose after start");
            end_run(1'b0);
        end
    endtask

    task automatic wait_ack(input int n, input string what);
        int cycles;
        cycles = 0;
        while (ack_seq < n && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (ack_seq < n) begin
            $display("timeout: checker did not finish the %s", what);
            end_run(1'b0);
        end
    endtask

    initial begin
        wait (chk_abort === 1'b1);
        end_run(1'b0);
    end

    initial begin : main
        int          idx;
        int          nframes;
        logic [63:0] thr;
        logic [63:0] extra;
        start      = 1'b0;
        img_we     = 1'b0;
        img_waddr  = '0;
        img_wdata  = '0;
        tb_paddr   = '0;
        tb_psel    = 1'b0;
        tb_penable = 1'b0;
        tb_pwrite  = 1'b0;
        tb_pwdata  = '0;
        req_seq    = 0;
        $readmemh("test/feature_core_stim.txt", stim);
        nframes = int'(stim[0]);
        idx     = 1;
        wait_ack(1, "reset state check");
        for (int f = 0; f < nframes; f++) begin
            thr   = stim[idx+1];
            extra = stim[idx+2];
            load_image(idx + 3);
            apb_access(REG_CTRL, 1'b1, stim[idx][31:0]);
            if (thr != 64'h100) apb_access(REG_THRESH, 1'b1, thr[31:0]);   // 100 keeps
            pulse_start();
            if (extra[0]) begin
                wait_busy();
                pulse_start();                              // must be ignored
                apb_access(REG_STATUS, 1'b1, 32'h1ff);      // read-only register
                apb_access(4'hc, 1'b0, 32'h0);              // unmapped
            end
            req_seq = f + 1;
            wait_ack(f + 2, "frame check");
            idx = idx + 13 + int'(stim[idx+11]);
        end
        end_run(fail_count == 0);
    end

endmodule

`default_nettype wire

// ==== test/feature_core_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module feature_core_checker import feature_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              done,
    input  logic              busy,
    input  logic              pslverr,
    input  logic              pready,
    input  logic [31:0]       prdata,
    input  kpt_t              kpt_rd_data,
    input  int                req_seq,
    output logic [KPT_AW-1:0] kpt_rd_addr,
    output logic [3:0]        chk_paddr,
    output logic              chk_psel,
    output logic              chk_penable,
    output logic              bus_own,
    output int                ack_seq,
    output int                pass_count,
    output int                fail_count,
    output logic              abort
);

    localparam int TIMEOUT = 2000;

    logic [63:0] stim [0:255];
    int          done_seen;
    int          err_seen;
    int          test_errs;

    // count done pulses and error responses
    always @(negedge clk) begin
        if (rst_n) begin
            if (done) done_seen <= done_seen + 1;
            if (pslverr) err_seen <= err_seen + 1;
        end
    end

    function automatic string test_name(input int n);
        case (n)
            0: return "reset state";
            1: return "filter off";
            2: return "filter on, bad apb accesses, start while busy";
            3: return "adaptive mode 0";
            4: return "adaptive mode 0, carried threshold";
            default: return "adaptive mode 1 saturation";
        endcase
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
            test_errs++;
        end
    endtask

    task automatic report(input int n);
        if (test_errs == 0) begin
            pass_count++;
            $display("test %0d (%s): pass", n, test_name(n));
        end else begin
            fail_count++;
            $display("test %0d (%s): fail, %0d mismatches", n, test_name(n), test_errs);
        end
        test_errs = 0;
    endtask

    task automatic stop_on_timeout(input string what);
        $display("timeout: %s did not happen within %0d cycles", what, TIMEOUT);
        abort = 1'b1;
        @(posedge clk);    // top ends the run here
    endtask

    task automatic wait_reset();
        int cycles;
        cycles = 0;
        while (!rst_n && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (!rst_n) stop_on_timeout("reset release");
    endtask

    task automatic wait_request(input int n);
        int cycles;
        cycles = 0;
        while (req_seq < n && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (req_seq < n) stop_on_timeout("frame start from the testbench");
    endtask

    task automatic wait_done(input int n);
        int cycles;
        cycles = 0;
        while (done_seen < n && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (done_seen < n) stop_on_timeout("done pulse");
    endtask

    task automatic apb_read(input logic [3:0] addr, output logic [31:0] data);
        @(posedge clk);
        #10;
        chk_paddr   = addr;
        chk_psel    = 1'b1;
        chk_penable = 1'b0;
        @(posedge clk);
        #10;
        chk_penable = 1'b1;
        @(negedge clk);
        data = prdata;         // stable mid access phase
        check_value("pready", 32'(pready), 32'd1);
        @(posedge clk);
        #10;
        chk_psel    = 1'b0;
        chk_penable = 1'b0;
    endtask

    task automatic read_kpt(input int addr, output kpt_t data);
        @(posedge clk);
        #10;
        kpt_rd_addr = KPT_AW'(addr);
        @(posedge clk);
        @(negedge clk);
        data = kpt_rd_data;
    endtask

    initial begin
        int          idx;
        int          nframes;
        int          exp_count;
        int          exp_err;
        logic [31:0] rd;
        kpt_t        kp;
        kpt_rd_addr = '0;
        chk_paddr   = '0;
        chk_psel    = 1'b0;
        chk_penable = 1'b0;
        bus_own     = 1'b0;
        ack_seq     = 0;
        pass_count  = 0;
        fail_count  = 0;
        abort       = 1'b0;
        test_errs   = 0;
        $readmemh("test/feature_core_stim.txt", stim);
        nframes = int'(stim[0]);
        idx     = 1;
        exp_err = 0;

        wait_reset();
        @(negedge clk);
        check_value("done after reset", 32'(done), 32'd0);
        check_value("busy after reset", 32'(busy), 32'd0);
        bus_own = 1'b1;
        apb_read(REG_CTRL, rd);
        check_value("CTRL after reset", rd, 32'd0);
        apb_read(REG_THRESH, rd);
        check_value("THRESH after reset", rd, 32'(THRESH_RESET));
        bus_own = 1'b0;
        report(0);
        ack_seq = 1;

        for (int f = 0; f < nframes; f++) begin
            exp_count = int'(stim[idx+11]);
            if (stim[idx+2][0]) exp_err = exp_err + 2;
            wait_request(f + 1);
            wait_done(f + 1);
            bus_own = 1'b1;
            for (int k = 0; k < exp_count; k++) begin
                read_kpt(k, kp);
                check_value($sformatf("keypoint %0d", k), 32'(kp), stim[idx+13+k][31:0]);
            end
            apb_read(REG_STATUS, rd);
            check_value("STATUS count", 32'(rd[6:0]), 32'(exp_count));
            check_value("STATUS busy", 32'(rd[8]), 32'd0);
            apb_read(REG_THRESH, rd);
            check_value("THRESH", rd, stim[idx+12][31:0]);
            apb_read(REG_CTRL, rd);
            check_value("CTRL", rd, stim[idx][31:0]);
            bus_own = 1'b0;
            check_value("done pulses", 32'(done_seen), 32'(f + 1));
            check_value("pslverr responses", 32'(err_seen), 32'(exp_err));
            report(f + 1);
            ack_seq = f + 2;
            idx = idx + 13 + exp_count;
        end
    end

endmodule

`default_nettype wire

// ==== hw/feature_core_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module feature_core_top import feature_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              start,
    output logic              done,
    output logic              busy,
    input  logic              img_we,
    input  logic [ROW_AW-1:0] img_waddr,
    input  img_row_t          img_wdata,
    input  logic [KPT_AW-1:0] kpt_rd_addr,
    output kpt_t              kpt_rd_data,
    input  logic [3:0]        paddr,
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  logic [31:0]       pwdata,
    output logic [31:0]       prdata,
    output logic              pready,
    output logic              pslverr
);

    mem_rw_if #(.payload_t(img_row_t), .AW(ROW_AW)) img_bus ();
    mem_rw_if #(.payload_t(img_row_t), .AW(ROW_AW)) blur_bus ();
    mem_rw_if #(.payload_t(kpt_t), .AW(KPT_AW))     kpt_bus ();

    logic              blur_start;
    logic              blur_done;
    logic              det_start;
    logic              det_done;
    logic [ROW_AW-1:0] blur_raddr;
    logic [ROW_AW-1:0] det_raddr;
    logic              frame_done;
    kpt_count_t        kpt_count;
    logic              filter_on;
    thresh_t           threshold;

    // external image load and keypoint readout
    assign img_bus.we    = img_we;
    assign img_bus.waddr = img_waddr;
    assign img_bus.wdata = img_wdata;
    assign kpt_bus.raddr = kpt_rd_addr;
    assign kpt_rd_data   = kpt_bus.rdata;

    row_mem #(.payload_t(img_row_t), .DEPTH(IMG_H)) u_img_mem (
        .clk (clk),
        .bus (img_bus.store)
    );

    row_mem #(.payload_t(img_row_t), .DEPTH(IMG_H)) u_blur_mem (
        .clk (clk),
        .bus (blur_bus.store)
    );

    row_mem #(.payload_t(kpt_t), .DEPTH(KPT_DEPTH)) u_kpt_mem (
        .clk (clk),
        .bus (kpt_bus.store)
    );

    detect_config_regs u_regs (
        .clk        (clk),
        .rst_n      (rst_n),
        .paddr      (paddr),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .frame_done (frame_done),
        .kpt_count  (kpt_count),
        .busy       (busy),
        .filter_on  (filter_on),
        .threshold  (threshold)
    );

    frame_sequencer u_seq (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .done       (done),
        .busy       (busy),
        .blur_start (blur_start),
        .blur_done  (blur_done),
        .det_start  (det_start),
        .det_done   (det_done),
        .blur_raddr (blur_raddr),
        .det_raddr  (det_raddr),
        .img        (img_bus.reader)
    );

    gaussian_blur u_blur (
        .clk       (clk),
        .rst_n     (rst_n),
        .run       (blur_start),
        .finished  (blur_done),
        .img_raddr (blur_raddr),
        .img_rdata (img_bus.rdata),
        .blur      (blur_bus.writer)
    );

    keypoint_detect u_detect (
        .clk        (clk),
        .rst_n      (rst_n),
        .run        (det_start),
        .finished   (det_done),
        .img_raddr  (det_raddr),
        .img_rdata  (img_bus.rdata),
        .blur       (blur_bus.reader),
        .kpt        (kpt_bus.writer),
        .filter_on  (filter_on),
        .threshold  (threshold),
        .kpt_count  (kpt_count),
        .frame_done (frame_done)
    );

endmodule

`default_nettype wire

// ==== hw/keypoint_detect.sv ====
`timescale 1ns/1ps
`default_nettype none

module keypoint_detect import feature_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              run,
    output logic              finished,
    output logic [ROW_AW-1:0] img_raddr,
    input  img_row_t          img_rdata,
    mem_rw_if.reader          blur,
    mem_rw_if.writer          kpt,
    input  logic              filter_on,
    input  thresh_t           threshold,
    output kpt_count_t        kpt_count,
    output logic              frame_done
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_READ,
        S_LOAD,
        S_SCAN
    } state_t;

    state_t            state;
    logic [ROW_AW-1:0] row_q;
    logic [2:0]        col_q;
    kpt_count_t        count_q;
    img_row_t          org_q;
    img_row_t          blr_q;
    pixel_t            org_pix;
    pixel_t            blr_pix;
    pixel_t            diff;
    logic              hit;

    // original and blurred rows are fetched together
    assign img_raddr  = row_q;
    assign blur.raddr = row_q;

    assign org_pix = org_q[col_q];
    assign blr_pix = blr_q[col_q];
    assign diff    = (org_pix >= blr_pix) ? org_pix - blr_pix : blr_pix - org_pix;
    assign hit     = filter_on ? (diff > threshold) : (diff != '0);

    assign kpt.we    = (state == S_SCAN) && hit;
    assign kpt.waddr = count_q[KPT_AW-1:0];    // packed list, row-major
    assign kpt.wdata = '{row: row_q, col: col_q};

    assign kpt_count  = count_q;
    assign frame_done = finished;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= S_IDLE;
            row_q    <= '0;
            col_q    <= '0;
            count_q  <= '0;
            finished <= 1'b0;
        end else begin
            finished <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (run) begin
                        row_q   <= '0;
                        count_q <= '0;
                        state   <= S_READ;
                    end
                end
                S_READ: state <= S_LOAD;
                S_LOAD: begin
                    col_q <= '0;
                    state <= S_SCAN;
                end
                S_SCAN: begin
                    if (hit) count_q <= count_q + 1'b1;
                    col_q <= col_q + 1'b1;
                    if (col_q == 3'(IMG_W - 1)) begin
                        if (row_q == ROW_AW'(IMG_H - 1)) begin
                            finished <= 1'b1;
                            state    <= S_IDLE;
                        end else begin
                            row_q <= row_q + 1'b1;
                            state <= S_READ;
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // row capture, read data valid in S_LOAD
    always_ff @(posedge clk) begin
        if (state == S_LOAD) begin
            org_q <= img_rdata;
            blr_q <= blur.rdata;
        end
    end

endmodule

`default_nettype wire

// ==== hw/gaussian_blur.sv ====
`timescale 1ns/1ps
`default_nettype none

module gaussian_blur import feature_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              run,
    output logic              finished,
    output logic [ROW_AW-1:0] img_raddr,
    input  img_row_t          img_rdata,
    mem_rw_if.writer          blur
);

    logic              active;
    logic [ROW_AW:0]   rd_cnt;      // IMG_H stands for the zero row below the image
    logic              shift_vld;
    logic [ROW_AW:0]   shift_idx;
    logic              wr_pend;
    logic [ROW_AW-1:0] wr_row;
    img_row_t          lb_up;
    img_row_t          lb_mid;
    img_row_t          lb_dn;
    img_row_t          row_in;
    img_row_t          blur_row;

    // 1-2-1 by 1-2-1 kernel around column c, zero outside the image
    function automatic pixel_t blur_pix(input img_row_t up, input img_row_t mid,
                                        input img_row_t dn, input int c);
        logic [11:0] acc;
        logic [9:0]  col_sum;
        acc = '0;
        for (int dc = -1; dc <= 1; dc++) begin
            if (c + dc >= 0 && c + dc < IMG_W) begin
                col_sum = {2'b00, up[c+dc]} + {1'b0, mid[c+dc], 1'b0} + {2'b00, dn[c+dc]};
                if (dc == 0) acc = acc + {1'b0, col_sum, 1'b0};
                else acc = acc + {2'b00, col_sum};
            end
        end
        return acc[11:4];    // divide by 16, truncate
    endfunction

    assign img_raddr = rd_cnt[ROW_AW-1:0];
    assign row_in    = (shift_idx == (ROW_AW+1)'(IMG_H)) ? '0 : img_rdata;

    always_comb begin
        for (int c = 0; c < IMG_W; c++) begin
            blur_row[c] = blur_pix(lb_up, lb_mid, lb_dn, c);
        end
    end

    assign blur.we    = wr_pend;
    assign blur.waddr = wr_row;
    assign blur.wdata = blur_row;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            active    <= 1'b0;
            rd_cnt    <= '0;
            shift_vld <= 1'b0;
            shift_idx <= '0;
            wr_pend   <= 1'b0;
            wr_row    <= '0;
            finished  <= 1'b0;
        end else begin
            shift_vld <= active;          // read data lands one cycle after the address
            shift_idx <= rd_cnt;
            wr_pend   <= shift_vld && (shift_idx != '0);
            wr_row    <= ROW_AW'(shift_idx - 1'b1);
            finished  <= wr_pend && (wr_row == ROW_AW'(IMG_H - 1));
            if (run) begin
                active <= 1'b1;
                rd_cnt <= '0;
            end else if (active) begin
                if (rd_cnt == (ROW_AW+1)'(IMG_H)) active <= 1'b0;
                rd_cnt <= rd_cnt + 1'b1;
            end
        end
    end

    // three-row window, starts with a zero row on top
    always_ff @(posedge clk) begin
        if (run) begin
            lb_up  <= '0;
            lb_mid <= '0;
            lb_dn  <= '0;
        end else if (shift_vld) begin
            lb_up  <= lb_mid;
            lb_mid <= lb_dn;
            lb_dn  <= row_in;
        end
    end

endmodule

`default_nettype wire

// ==== hw/frame_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module frame_sequencer import feature_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              start,
    output logic              done,
    output logic              busy,
    output logic              blur_start,
    input  logic              blur_done,
    output logic              det_start,
    input  logic              det_done,
    input  logic [ROW_AW-1:0] blur_raddr,
    input  logic [ROW_AW-1:0] det_raddr,
    mem_rw_if.reader          img
);

    phase_t phase;

    assign busy = (phase != PH_IDLE);

    // shared image read port follows the active pass
    assign img.raddr = (phase == PH_DETECT) ? det_raddr : blur_raddr;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            phase      <= PH_IDLE;
            blur_start <= 1'b0;
            det_start  <= 1'b0;
            done       <= 1'b0;
        end else begin
            blur_start <= 1'b0;
            det_start  <= 1'b0;
            done       <= 1'b0;
            case (phase)
                PH_IDLE: begin
                    if (start) begin
                        phase      <= PH_BLUR;
                        blur_start <= 1'b1;
                    end
                end
                PH_BLUR: begin
                    if (blur_done) begin
                        phase     <= PH_DETECT;
                        det_start <= 1'b1;
                    end
                end
                PH_DETECT: begin
                    if (det_done) begin
                        phase <= PH_IDLE;
                        done  <= 1'b1;     // busy drops on this same cycle
                    end
                end
                default: phase <= PH_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hw/detect_config_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module detect_config_regs import feature_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [3:0]  paddr,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    input  logic        frame_done,
    input  kpt_count_t  kpt_count,
    input  logic        busy,
    output logic        filter_on,
    output thresh_t     threshold
);

    logic [2:0] ctrl_q;        // {adaptive_mode, adaptive_on, filter_on}
    thresh_t    thresh_q;
    kpt_count_t last_count;
    kpt_count_t target;
    logic       access;
    logic       mapped;

    assign access  = psel && penable;
    assign mapped  = paddr inside {REG_CTRL, REG_THRESH, REG_STATUS};
    assign pready  = 1'b1;     // no wait states
    assign pslverr = access && (!mapped || (pwrite && paddr == REG_STATUS));

    assign filter_on = ctrl_q[0];
    assign threshold = thresh_q;
    assign target    = ctrl_q[2] ? TARGET_ACCURACY : TARGET_THROUGHPUT;

    always_comb begin
        case (paddr)
            REG_CTRL:   prdata = {29'd0, ctrl_q};
            REG_THRESH: prdata = {24'd0, thresh_q};
            REG_STATUS: prdata = {23'd0, busy, 1'b0, last_count};
            default:    prdata = 32'd0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ctrl_q     <= 3'd0;
            thresh_q   <= THRESH_RESET;
            last_count <= '0;
        end else begin
            if (access && pwrite && paddr == REG_CTRL) ctrl_q <= pwdata[2:0];
            if (access && pwrite && paddr == REG_THRESH) thresh_q <= pwdata[7:0];

            if (frame_done) begin
                last_count <= kpt_count;
                // adaptive step toward the target count of the selected mode
                if (ctrl_q[1]) begin
                    if (kpt_count > target) begin
                        thresh_q <= (thresh_q > 8'hFF - THRESH_STEP) ? 8'hFF
                                                                     : thresh_q + THRESH_STEP;
                    end else if (kpt_count < target) begin
                        thresh_q <= (thresh_q < THRESH_STEP) ? 8'h00 : thresh_q - THRESH_STEP;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/row_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module row_mem import feature_pkg::*; #(
    parameter type payload_t = img_row_t,
    parameter int  DEPTH     = IMG_H
) (
    input  logic     clk,
    mem_rw_if.store  bus
);

    payload_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (bus.we) begin
            mem[bus.waddr] <= bus.wdata;
        end
        bus.rdata <= mem[bus.raddr];    // registered read
    end

endmodule

`default_nettype wire

// ==== hw/mem_rw_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// one write port and one read port of a row memory
interface mem_rw_if #(
    parameter type payload_t = logic [7:0],
    parameter int  AW        = 3
);
    logic          we;
    logic [AW-1:0] waddr;
    payload_t      wdata;
    logic [AW-1:0] raddr;
    payload_t      rdata;    // word at raddr, one cycle later

    modport store  (input we, input waddr, input wdata, input raddr, output rdata);
    modport writer (output we, output waddr, output wdata);
    modport reader (output raddr, input rdata);

endinterface

`default_nettype wire

// ==== hw/feature_pkg.sv ====
`default_nettype none

package feature_pkg;

    // image geometry, one memory word per row
    localparam int IMG_W  = 8;
    localparam int IMG_H  = 8;
    localparam int PIX_W  = 8;
    localparam int ROW_AW = 3;

    typedef logic [PIX_W-1:0] pixel_t;
    typedef pixel_t [IMG_W-1:0] img_row_t;    // column c sits at index c

    // keypoint storage
    localparam int KPT_DEPTH = 64;
    localparam int KPT_AW    = 6;

    typedef struct packed {
        logic [2:0] row;
        logic [2:0] col;
    } kpt_t;

    typedef logic [6:0] kpt_count_t;          // 0..64
    typedef logic [7:0] thresh_t;

    // apb register map
    localparam logic [3:0] REG_CTRL   = 4'h0;
    localparam logic [3:0] REG_THRESH = 4'h4;
    localparam logic [3:0] REG_STATUS = 4'h8;

    localparam thresh_t THRESH_RESET = 8'd16;

    // adaptive controller targets, mode 0 and mode 1
    localparam kpt_count_t TARGET_THROUGHPUT = 7'd8;
    localparam kpt_count_t TARGET_ACCURACY   = 7'd20;
    localparam thresh_t    THRESH_STEP       = 8'd4;

    typedef enum logic [1:0] {
        PH_IDLE,
        PH_BLUR,
        PH_DETECT
    } phase_t;

endpackage

`default_nettype wire
